// File: rtl/shim_pkg.sv
/* Data port shim definitions */
package shim_pkg;

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned MaxOutstanding = 8;
  localparam int unsigned MetaIdWidth    = $clog2(MaxOutstanding);

  // Atomic opcodes
  localparam int unsigned         AmoWidth = 4;
  localparam logic [AmoWidth-1:0] AmoNone  = 4'd0;
  localparam logic [AmoWidth-1:0] AmoSwap  = 4'd1;
  localparam logic [AmoWidth-1:0] AmoAdd   = 4'd2;

  // Banks take the low target indices, the SoC port the last one
  localparam int unsigned NrTcdm      = 2;
  localparam int unsigned NrTargets   = NrTcdm + 1;
  localparam int unsigned TgtSelWidth = $clog2(NrTargets);

  // TCDM region, interleaved word by word
  localparam logic [AddrWidth-1:0] TcdmBase     = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TcdmSize     = 32'h0000_1000;
  localparam int unsigned          BankWords    = 512;
  localparam int unsigned          BankIdxWidth = $clog2(BankWords);
  localparam int unsigned          BankSelBit   = 2;
  localparam int unsigned          BankIdxLsb   = 3;

endpackage

// File: rtl/meta_id_fifo.sv
/* In-order ID FIFO */
`timescale 1ns/100ps

module meta_id_fifo (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             push_i,
  input  logic [shim_pkg::MetaIdWidth-1:0] data_i,
  input  logic                             pop_i,
  output logic [shim_pkg::MetaIdWidth-1:0] data_o,
  output logic                             full_o
);

  import shim_pkg::*;

  logic [MetaIdWidth-1:0] mem_q [MaxOutstanding];
  logic [MetaIdWidth-1:0] wr_ptr_q;
  logic [MetaIdWidth-1:0] rd_ptr_q;
  logic [MetaIdWidth:0]   count_q;

  // Depth is a power of two, pointers wrap by themselves
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o = mem_q[rd_ptr_q];
  // Count reaches MaxOutstanding only when its top bit is set
  assign full_o = count_q[MetaIdWidth];

endmodule

// File: rtl/addr_demux.sv
/* Address demux and response arbiter */
`timescale 1ns/100ps

module addr_demux (
  input  logic                                                     clk_i,
  input  logic                                                     arst_n_i,
  // Core side
  input  logic [shim_pkg::AddrWidth-1:0]                           req_addr_i,
  input  logic                                                     req_write_i,
  input  logic [shim_pkg::AmoWidth-1:0]                            req_amo_i,
  input  logic [shim_pkg::DataWidth-1:0]                           req_data_i,
  input  logic [shim_pkg::StrbWidth-1:0]                           req_strb_i,
  input  logic [shim_pkg::MetaIdWidth-1:0]                         req_id_i,
  input  logic                                                     req_valid_i,
  output logic                                                     req_ready_o,
  output logic                                                     resp_valid_o,
  input  logic                                                     resp_ready_i,
  output logic [shim_pkg::DataWidth-1:0]                           resp_data_o,
  output logic                                                     resp_write_o,
  output logic                                                     resp_error_o,
  output logic [shim_pkg::MetaIdWidth-1:0]                         resp_id_o,
  // Target side
  output logic [shim_pkg::NrTargets-1:0]                           tgt_req_valid_o,
  input  logic [shim_pkg::NrTargets-1:0]                           tgt_req_ready_i,
  output logic [shim_pkg::NrTargets-1:0][shim_pkg::AddrWidth-1:0]   tgt_req_addr_o,
  output logic [shim_pkg::NrTargets-1:0]                           tgt_req_write_o,
  output logic [shim_pkg::NrTargets-1:0][shim_pkg::AmoWidth-1:0]    tgt_req_amo_o,
  output logic [shim_pkg::NrTargets-1:0][shim_pkg::DataWidth-1:0]   tgt_req_data_o,
  output logic [shim_pkg::NrTargets-1:0][shim_pkg::StrbWidth-1:0]   tgt_req_strb_o,
  output logic [shim_pkg::NrTargets-1:0][shim_pkg::MetaIdWidth-1:0] tgt_req_id_o,
  input  logic [shim_pkg::NrTargets-1:0]                           tgt_resp_valid_i,
  output logic [shim_pkg::NrTargets-1:0]                           tgt_resp_ready_o,
  input  logic [shim_pkg::NrTargets-1:0][shim_pkg::DataWidth-1:0]   tgt_resp_data_i,
  input  logic [shim_pkg::NrTargets-1:0]                           tgt_resp_write_i,
  input  logic [shim_pkg::NrTargets-1:0]                           tgt_resp_error_i,
  input  logic [shim_pkg::NrTargets-1:0][shim_pkg::MetaIdWidth-1:0] tgt_resp_id_i
);

  import shim_pkg::*;

  logic                   in_tcdm;
  logic [TgtSelWidth-1:0] req_sel;
  logic [TgtSelWidth-1:0] rr_ptr_q;
  logic [TgtSelWidth-1:0] grant;
  logic [TgtSelWidth-1:0] grant_next;

  // Bank picked by one address bit, everything else to SoC
  assign in_tcdm = (req_addr_i - TcdmBase) < TcdmSize;
  assign req_sel = in_tcdm ? TgtSelWidth'(req_addr_i[BankSelBit]) : TgtSelWidth'(NrTcdm);

  assign req_ready_o = tgt_req_ready_i[req_sel];

  for (genvar t = 0; t < NrTargets; t++) begin : gen_tgt
    assign tgt_req_valid_o[t] = req_valid_i && (req_sel == TgtSelWidth'(t));
    assign tgt_req_addr_o[t]  = req_addr_i;
    assign tgt_req_write_o[t] = req_write_i;
    assign tgt_req_amo_o[t]   = req_amo_i;
    assign tgt_req_data_o[t]  = req_data_i;
    assign tgt_req_strb_o[t]  = req_strb_i;
    assign tgt_req_id_o[t]    = req_id_i;
    assign tgt_resp_ready_o[t] = resp_ready_i && tgt_resp_valid_i[t]
                                 && (grant == TgtSelWidth'(t));
  end

  // First valid response at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    grant = rr_ptr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < NrTargets; k++) begin
      idx = (rr_ptr_q + k) % NrTargets;
      if (!found && tgt_resp_valid_i[idx]) begin
        grant = TgtSelWidth'(idx);
        found = 1'b1;
      end
    end
  end

  assign grant_next = (grant == TgtSelWidth'(NrTargets - 1)) ? '0 : grant + 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
    end else if (resp_valid_o) begin
      // A stalled grant is pinned so its payload stays put
      rr_ptr_q <= resp_ready_i ? grant_next : grant;
    end
  end

  assign resp_valid_o = |tgt_resp_valid_i;
  assign resp_data_o  = tgt_resp_data_i[grant];
  assign resp_write_o = tgt_resp_write_i[grant];
  assign resp_error_o = tgt_resp_error_i[grant];
  assign resp_id_o    = tgt_resp_id_i[grant];

endmodule

// File: rtl/tcdm_bank.sv
/* TCDM bank with atomics */
`timescale 1ns/100ps

module tcdm_bank (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [shim_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic                             req_wen_i,
  input  logic [shim_pkg::DataWidth-1:0]   req_wdata_i,
  input  logic [shim_pkg::AmoWidth-1:0]    req_amo_i,
  input  logic [shim_pkg::MetaIdWidth-1:0] req_id_i,
  input  logic [shim_pkg::StrbWidth-1:0]   req_be_i,
  output logic                             resp_valid_o,
  input  logic                             resp_ready_i,
  output logic [shim_pkg::DataWidth-1:0]   resp_rdata_o,
  output logic [shim_pkg::MetaIdWidth-1:0] resp_id_o,
  output logic                             resp_wen_o
);

  import shim_pkg::*;

  logic [DataWidth-1:0]    mem_q [BankWords];
  logic [BankIdxWidth-1:0] word_idx;
  logic [DataWidth-1:0]    rd_word;
  logic [DataWidth-1:0]    wr_word;
  logic                    is_amo;
  logic                    accept;
  logic                    resp_valid_q;

  // Response register full and not draining blocks new requests
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  assign word_idx = req_addr_i[BankIdxLsb +: BankIdxWidth];
  assign rd_word  = mem_q[word_idx];
  assign is_amo   = req_amo_i != AmoNone;

  always_comb begin
    wr_word = rd_word;
    case (req_amo_i)
      AmoSwap: wr_word = req_wdata_i;
      AmoAdd:  wr_word = rd_word + req_wdata_i;
      default: begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (req_be_i[b]) begin
            wr_word[8*b +: 8] = req_wdata_i[8*b +: 8];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_wen_i || is_amo) begin
        mem_q[word_idx] <= wr_word;
      end
      // Plain writes answer with zero, AMOs with the old word
      resp_rdata_o <= (req_wen_i && !is_amo) ? '0 : rd_word;
      resp_id_o    <= req_id_i;
      resp_wen_o   <= req_wen_i;
    end
  end

  assign resp_valid_o = resp_valid_q;

endmodule

// File: rtl/tcdm_shim.sv
/* Core to TCDM and SoC shim */
`timescale 1ns/100ps

module tcdm_shim (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  // Core port
  input  logic [shim_pkg::AddrWidth-1:0]                        data_qaddr_i,
  input  logic                                                  data_qwrite_i,
  input  logic [shim_pkg::AmoWidth-1:0]                         data_qamo_i,
  input  logic [shim_pkg::DataWidth-1:0]                        data_qdata_i,
  input  logic [shim_pkg::StrbWidth-1:0]                        data_qstrb_i,
  input  logic [shim_pkg::MetaIdWidth-1:0]                      data_qid_i,
  input  logic                                                  data_qvalid_i,
  output logic                                                  data_qready_o,
  output logic [shim_pkg::DataWidth-1:0]                        data_pdata_o,
  output logic                                                  data_pwrite_o,
  output logic                                                  data_perror_o,
  output logic [shim_pkg::MetaIdWidth-1:0]                      data_pid_o,
  output logic                                                  data_pvalid_o,
  input  logic                                                  data_pready_i,
  // SoC port
  output logic [shim_pkg::AddrWidth-1:0]                        soc_qaddr_o,
  output logic                                                  soc_qwrite_o,
  output logic [shim_pkg::AmoWidth-1:0]                         soc_qamo_o,
  output logic [shim_pkg::DataWidth-1:0]                        soc_qdata_o,
  output logic [shim_pkg::StrbWidth-1:0]                        soc_qstrb_o,
  output logic                                                  soc_qvalid_o,
  input  logic                                                  soc_qready_i,
  input  logic [shim_pkg::DataWidth-1:0]                        soc_pdata_i,
  input  logic                                                  soc_pwrite_i,
  input  logic                                                  soc_perror_i,
  input  logic                                                  soc_pvalid_i,
  output logic                                                  soc_pready_o,
  // TCDM ports
  output logic [shim_pkg::NrTcdm-1:0]                           tcdm_req_valid_o,
  input  logic [shim_pkg::NrTcdm-1:0]                           tcdm_req_ready_i,
  output logic [shim_pkg::NrTcdm-1:0][shim_pkg::AddrWidth-1:0]   tcdm_req_addr_o,
  output logic [shim_pkg::NrTcdm-1:0]                           tcdm_req_wen_o,
  output logic [shim_pkg::NrTcdm-1:0][shim_pkg::DataWidth-1:0]   tcdm_req_wdata_o,
  output logic [shim_pkg::NrTcdm-1:0][shim_pkg::AmoWidth-1:0]    tcdm_req_amo_o,
  output logic [shim_pkg::NrTcdm-1:0][shim_pkg::MetaIdWidth-1:0] tcdm_req_id_o,
  output logic [shim_pkg::NrTcdm-1:0][shim_pkg::StrbWidth-1:0]   tcdm_req_be_o,
  input  logic [shim_pkg::NrTcdm-1:0]                           tcdm_resp_valid_i,
  output logic [shim_pkg::NrTcdm-1:0]                           tcdm_resp_ready_o,
  input  logic [shim_pkg::NrTcdm-1:0][shim_pkg::DataWidth-1:0]   tcdm_resp_rdata_i,
  input  logic [shim_pkg::NrTcdm-1:0][shim_pkg::MetaIdWidth-1:0] tcdm_resp_id_i,
  input  logic [shim_pkg::NrTcdm-1:0]                           tcdm_resp_wen_i
);

  import shim_pkg::*;

  logic                   soc_req_valid;
  logic                   soc_req_ready;
  logic [MetaIdWidth-1:0] soc_req_id;
  logic [MetaIdWidth-1:0] soc_resp_id;
  logic [MetaIdWidth-1:0] read_id;
  logic [MetaIdWidth-1:0] write_id;
  logic                   read_ids_full;
  logic                   write_ids_full;
  logic                   id_full;

  // Hold SoC requests back while their ID FIFO is full
  assign id_full       = soc_qwrite_o ? write_ids_full : read_ids_full;
  assign soc_qvalid_o  = soc_req_valid && !id_full;
  assign soc_req_ready = soc_qready_i && !id_full;

  // SoC answers reads in order and writes in order
  assign soc_resp_id = soc_pwrite_i ? write_id : read_id;

  meta_id_fifo u_soc_read_ids (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (soc_qvalid_o && soc_qready_i && !soc_qwrite_o),
    .data_i   (soc_req_id),
    .pop_i    (soc_pvalid_i && soc_pready_o && !soc_pwrite_i),
    .data_o   (read_id),
    .full_o   (read_ids_full)
  );

  meta_id_fifo u_soc_write_ids (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (soc_qvalid_o && soc_qready_i && soc_qwrite_o),
    .data_i   (soc_req_id),
    .pop_i    (soc_pvalid_i && soc_pready_o && soc_pwrite_i),
    .data_o   (write_id),
    .full_o   (write_ids_full)
  );

  // SoC sits on the top target index
  addr_demux u_addr_demux (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_addr_i       (data_qaddr_i),
    .req_write_i      (data_qwrite_i),
    .req_amo_i        (data_qamo_i),
    .req_data_i       (data_qdata_i),
    .req_strb_i       (data_qstrb_i),
    .req_id_i         (data_qid_i),
    .req_valid_i      (data_qvalid_i),
    .req_ready_o      (data_qready_o),
    .resp_valid_o     (data_pvalid_o),
    .resp_ready_i     (data_pready_i),
    .resp_data_o      (data_pdata_o),
    .resp_write_o     (data_pwrite_o),
    .resp_error_o     (data_perror_o),
    .resp_id_o        (data_pid_o),
    .tgt_req_valid_o  ({soc_req_valid, tcdm_req_valid_o}),
    .tgt_req_ready_i  ({soc_req_ready, tcdm_req_ready_i}),
    .tgt_req_addr_o   ({soc_qaddr_o, tcdm_req_addr_o}),
    .tgt_req_write_o  ({soc_qwrite_o, tcdm_req_wen_o}),
    .tgt_req_amo_o    ({soc_qamo_o, tcdm_req_amo_o}),
    .tgt_req_data_o   ({soc_qdata_o, tcdm_req_wdata_o}),
    .tgt_req_strb_o   ({soc_qstrb_o, tcdm_req_be_o}),
    .tgt_req_id_o     ({soc_req_id, tcdm_req_id_o}),
    .tgt_resp_valid_i ({soc_pvalid_i, tcdm_resp_valid_i}),
    .tgt_resp_ready_o ({soc_pready_o, tcdm_resp_ready_o}),
    .tgt_resp_data_i  ({soc_pdata_i, tcdm_resp_rdata_i}),
    .tgt_resp_write_i ({soc_pwrite_i, tcdm_resp_wen_i}),
    .tgt_resp_error_i ({soc_perror_i, {NrTcdm{1'b0}}}),
    .tgt_resp_id_i    ({soc_resp_id, tcdm_resp_id_i})
  );

endmodule

// File: rtl/shim_subsystem_top.sv
/* Shim subsystem top */
`timescale 1ns/100ps

module shim_subsystem_top (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // Core port
  input  logic [shim_pkg::AddrWidth-1:0]   data_qaddr_i,
  input  logic                             data_qwrite_i,
  input  logic [shim_pkg::AmoWidth-1:0]    data_qamo_i,
  input  logic [shim_pkg::DataWidth-1:0]   data_qdata_i,
  input  logic [shim_pkg::StrbWidth-1:0]   data_qstrb_i,
  input  logic [shim_pkg::MetaIdWidth-1:0] data_qid_i,
  input  logic                             data_qvalid_i,
  output logic                             data_qready_o,
  output logic [shim_pkg::DataWidth-1:0]   data_pdata_o,
  output logic                             data_pwrite_o,
  output logic                             data_perror_o,
  output logic [shim_pkg::MetaIdWidth-1:0] data_pid_o,
  output logic                             data_pvalid_o,
  input  logic                             data_pready_i,
  // SoC port
  output logic [shim_pkg::AddrWidth-1:0]   soc_qaddr_o,
  output logic                             soc_qwrite_o,
  output logic [shim_pkg::AmoWidth-1:0]    soc_qamo_o,
  output logic [shim_pkg::DataWidth-1:0]   soc_qdata_o,
  output logic [shim_pkg::StrbWidth-1:0]   soc_qstrb_o,
  output logic                             soc_qvalid_o,
  input  logic                             soc_qready_i,
  input  logic [shim_pkg::DataWidth-1:0]   soc_pdata_i,
  input  logic                             soc_pwrite_i,
  input  logic                             soc_perror_i,
  input  logic                             soc_pvalid_i,
  output logic                             soc_pready_o
);

  import shim_pkg::*;

  logic [NrTcdm-1:0]                  tcdm_req_valid;
  logic [NrTcdm-1:0]                  tcdm_req_ready;
  logic [NrTcdm-1:0][AddrWidth-1:0]   tcdm_req_addr;
  logic [NrTcdm-1:0]                  tcdm_req_wen;
  logic [NrTcdm-1:0][DataWidth-1:0]   tcdm_req_wdata;
  logic [NrTcdm-1:0][AmoWidth-1:0]    tcdm_req_amo;
  logic [NrTcdm-1:0][MetaIdWidth-1:0] tcdm_req_id;
  logic [NrTcdm-1:0][StrbWidth-1:0]   tcdm_req_be;
  logic [NrTcdm-1:0]                  tcdm_resp_valid;
  logic [NrTcdm-1:0]                  tcdm_resp_ready;
  logic [NrTcdm-1:0][DataWidth-1:0]   tcdm_resp_rdata;
  logic [NrTcdm-1:0][MetaIdWidth-1:0] tcdm_resp_id;
  logic [NrTcdm-1:0]                  tcdm_resp_wen;

  // Core and SoC ports share their names with the shim
  tcdm_shim u_tcdm_shim (
    .*,
    .tcdm_req_valid_o  (tcdm_req_valid),
    .tcdm_req_ready_i  (tcdm_req_ready),
    .tcdm_req_addr_o   (tcdm_req_addr),
    .tcdm_req_wen_o    (tcdm_req_wen),
    .tcdm_req_wdata_o  (tcdm_req_wdata),
    .tcdm_req_amo_o    (tcdm_req_amo),
    .tcdm_req_id_o     (tcdm_req_id),
    .tcdm_req_be_o     (tcdm_req_be),
    .tcdm_resp_valid_i (tcdm_resp_valid),
    .tcdm_resp_ready_o (tcdm_resp_ready),
    .tcdm_resp_rdata_i (tcdm_resp_rdata),
    .tcdm_resp_id_i    (tcdm_resp_id),
    .tcdm_resp_wen_i   (tcdm_resp_wen)
  );

  tcdm_bank u_tcdm_bank_0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (tcdm_req_valid[0]),
    .req_ready_o  (tcdm_req_ready[0]),
    .req_addr_i   (tcdm_req_addr[0]),
    .req_wen_i    (tcdm_req_wen[0]),
    .req_wdata_i  (tcdm_req_wdata[0]),
    .req_amo_i    (tcdm_req_amo[0]),
    .req_id_i     (tcdm_req_id[0]),
    .req_be_i     (tcdm_req_be[0]),
    .resp_valid_o (tcdm_resp_valid[0]),
    .resp_ready_i (tcdm_resp_ready[0]),
    .resp_rdata_o (tcdm_resp_rdata[0]),
    .resp_id_o    (tcdm_resp_id[0]),
    .resp_wen_o   (tcdm_resp_wen[0])
  );

  tcdm_bank u_tcdm_bank_1 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (tcdm_req_valid[1]),
    .req_ready_o  (tcdm_req_ready[1]),
    .req_addr_i   (tcdm_req_addr[1]),
    .req_wen_i    (tcdm_req_wen[1]),
    .req_wdata_i  (tcdm_req_wdata[1]),
    .req_amo_i    (tcdm_req_amo[1]),
    .req_id_i     (tcdm_req_id[1]),
    .req_be_i     (tcdm_req_be[1]),
    .resp_valid_o (tcdm_resp_valid[1]),
    .resp_ready_i (tcdm_resp_ready[1]),
    .resp_rdata_o (tcdm_resp_rdata[1]),
    .resp_id_o    (tcdm_resp_id[1]),
    .resp_wen_o   (tcdm_resp_wen[1])
  );

endmodule

// File: test/tb_clk_gen.sv
/* Testbench clock and reset */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned Period      = 20,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Release between edges
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #(Period / 4);
    arst_n_o = 1'b1;
  end

endmodule

// File: test/tb_shim_top.sv
/* Shim subsystem testbench */
`timescale 1ns/100ps

module tb_shim_top;

  import shim_pkg::*;

  localparam int unsigned ClkPeriod = 20;
  localparam int unsigned NrTests   = 5;
  localparam int unsigned TcdmWords = TcdmSize / 4;
  localparam int unsigned Len1      = 2 * TcdmWords;
  localparam int unsigned Len2      = 32;
  localparam int unsigned Len3      = 32;
  localparam int unsigned Len4      = 32;
  localparam int unsigned Len5      = 200;
  localparam int unsigned TotalTxns = Len1 + Len2 + Len3 + Len4 + Len5;

  logic                   clk_i;
  logic                   arst_n_i;
  logic [AddrWidth-1:0]   data_qaddr_i  = '0;
  logic                   data_qwrite_i = 1'b0;
  logic [AmoWidth-1:0]    data_qamo_i   = '0;
  logic [DataWidth-1:0]   data_qdata_i  = '0;
  logic [StrbWidth-1:0]   data_qstrb_i  = '0;
  logic [MetaIdWidth-1:0] data_qid_i    = '0;
  logic                   data_qvalid_i = 1'b0;
  logic                   data_qready_o;
  logic [DataWidth-1:0]   data_pdata_o;
  logic                   data_pwrite_o;
  logic                   data_perror_o;
  logic [MetaIdWidth-1:0] data_pid_o;
  logic                   data_pvalid_o;
  logic                   data_pready_i = 1'b0;
  logic [AddrWidth-1:0]   soc_qaddr_o;
  logic                   soc_qwrite_o;
  logic [AmoWidth-1:0]    soc_qamo_o;
  logic [DataWidth-1:0]   soc_qdata_o;
  logic [StrbWidth-1:0]   soc_qstrb_o;
  logic                   soc_qvalid_o;
  logic                   soc_qready_i  = 1'b0;
  logic [DataWidth-1:0]   soc_pdata_i   = '0;
  logic                   soc_pwrite_i  = 1'b0;
  logic                   soc_perror_i  = 1'b0;
  logic                   soc_pvalid_i  = 1'b0;
  logic                   soc_pready_o;

  logic [AddrWidth-1:0] stim_addr  [TotalTxns];
  logic                 stim_write [TotalTxns];
  logic [AmoWidth-1:0]  stim_amo   [TotalTxns];
  logic [DataWidth-1:0] stim_data  [TotalTxns];
  logic [StrbWidth-1:0] stim_strb  [TotalTxns];

  // Reference image of both banks, one entry per TCDM word
  logic [DataWidth-1:0]      ref_mem [TcdmWords];
  logic [MaxOutstanding-1:0] pending = '0;
  logic [DataWidth-1:0]      exp_data     [MaxOutstanding];
  logic                      exp_write    [MaxOutstanding];
  logic                      exp_error    [MaxOutstanding];
  logic                      exp_tcdm     [MaxOutstanding];
  int unsigned               accept_cycle [MaxOutstanding];
  logic [AddrWidth-1:0]      soc_addr_q  [$];
  logic                      soc_write_q [$];

  string       test_name  [NrTests] = '{"tcdm write and read", "byte strobes", "atomics",
                                        "soc ids in flight", "mixed traffic with stalls"};
  int unsigned test_len   [NrTests] = '{Len1, Len2, Len3, Len4, Len5};
  int unsigned test_stall [NrTests] = '{0, 25, 25, 30, 50};

  int unsigned gen_count     = 0;
  int unsigned issue_count   = 0;
  int unsigned issue_limit   = 0;
  int unsigned resp_count    = 0;
  int unsigned check_count   = 0;
  int unsigned err_count     = 0;
  int unsigned cycle         = 0;
  int unsigned stall_pct     = 0;
  logic        check_latency = 1'b0;
  logic        q_fired       = 1'b0;
  logic        s_fired       = 1'b0;
  logic [31:0] gen_rng       = 32'h80b3;

  tb_clk_gen #(
    .Period      (ClkPeriod),
    .ResetCycles (5)
  ) u_tb_clk_gen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  shim_subsystem_top u_shim_subsystem_top (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] gen_rand();
    gen_rng = xorshift32(gen_rng);
    return gen_rng;
  endfunction

  function automatic logic [31:0] tcdm_word_addr(input logic [31:0] r);
    return (r % TcdmSize) & ~32'h3;
  endfunction

  // Bit 12 set keeps the address above the TCDM region
  function automatic logic [31:0] soc_word_addr(input logic [31:0] r);
    return (r | TcdmSize) & ~32'h3;
  endfunction

  function automatic void print_error(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
  endfunction

  task automatic add_txn(input logic [31:0] addr, input logic write, input logic [3:0] amo,
                         input logic [31:0] data, input logic [3:0] strb);
    stim_addr[gen_count]  = addr;
    stim_write[gen_count] = write;
    stim_amo[gen_count]   = amo;
    stim_data[gen_count]  = data;
    stim_strb[gen_count]  = strb;
    gen_count++;
  endtask

  // Response checks and request bookkeeping
  always @(posedge clk_i) begin : monitor
    logic [MetaIdWidth-1:0] id;
    logic [DataWidth-1:0]   old;
    int unsigned            widx;
    if (arst_n_i === 1'b1) begin
      cycle++;
      if (data_pvalid_o && data_pready_i) begin
        id = data_pid_o;
        check_count++;
        assert (pending[id])
        else begin
          print_error($sformatf("response with ID %0d that is not outstanding", id));
          err_count++;
        end
        if (pending[id]) begin
          assert (data_pdata_o === exp_data[id] && data_pwrite_o === exp_write[id]
                  && data_perror_o === exp_error[id])
          else begin
            print_error($sformatf("ID %0d got data %h write %b error %b, expected %h %b %b",
                                  id, data_pdata_o, data_pwrite_o, data_perror_o,
                                  exp_data[id], exp_write[id], exp_error[id]));
            err_count++;
          end
          if (check_latency && exp_tcdm[id]) begin
            assert (cycle == accept_cycle[id] + 1)
            else begin
              print_error($sformatf("ID %0d answered after %0d cycles instead of 1",
                                    id, cycle - accept_cycle[id]));
              err_count++;
            end
          end
          pending[id] = 1'b0;
          resp_count++;
        end
      end
      q_fired = data_qvalid_i && data_qready_o;
      if (q_fired) begin
        id                = data_qid_i;
        pending[id]       = 1'b1;
        accept_cycle[id]  = cycle;
        exp_write[id]     = data_qwrite_i;
        exp_tcdm[id]      = data_qaddr_i < TcdmSize;
        if (exp_tcdm[id]) begin
          widx          = (data_qaddr_i - TcdmBase) / 4;
          old           = ref_mem[widx];
          exp_error[id] = 1'b0;
          exp_data[id]  = (data_qwrite_i && data_qamo_i == AmoNone) ? '0 : old;
          if (data_qamo_i == AmoSwap) begin
            ref_mem[widx] = data_qdata_i;
          end else if (data_qamo_i == AmoAdd) begin
            ref_mem[widx] = old + data_qdata_i;
          end else if (data_qwrite_i) begin
            for (int b = 0; b < StrbWidth; b++) begin
              if (data_qstrb_i[b]) begin
                ref_mem[widx][8*b +: 8] = data_qdata_i[8*b +: 8];
              end
            end
          end
        end else begin
          exp_data[id]  = data_qwrite_i ? '0 : ~data_qaddr_i;
          exp_error[id] = data_qaddr_i[4];
        end
      end
      // SoC responder queue, answered in acceptance order
      if (soc_qvalid_o && soc_qready_i) begin
        check_count++;
        assert (soc_qaddr_o >= TcdmSize)
        else begin
          print_error($sformatf("TCDM address %h routed to the SoC port", soc_qaddr_o));
          err_count++;
        end
        // SoC sees the core request unchanged and in the same cycle
        assert (q_fired && soc_qaddr_o === data_qaddr_i && soc_qwrite_o === data_qwrite_i
                && soc_qamo_o === data_qamo_i && soc_qdata_o === data_qdata_i
                && soc_qstrb_o === data_qstrb_i)
        else begin
          print_error($sformatf("SoC request %h %b %h %h %h differs from the core request",
                                soc_qaddr_o, soc_qwrite_o, soc_qamo_o, soc_qdata_o,
                                soc_qstrb_o));
          err_count++;
        end
        soc_addr_q.push_back(soc_qaddr_o);
        soc_write_q.push_back(soc_qwrite_o);
      end
      s_fired = soc_pvalid_i && soc_pready_o;
      if (s_fired) begin
        void'(soc_addr_q.pop_front());
        void'(soc_write_q.pop_front());
      end
    end
  end

  always @(negedge clk_i) begin : driver
    int          free_id;
    logic [31:0] rnd;
    if (arst_n_i === 1'b1) begin
      rnd           = gen_rand();
      data_pready_i = (rnd % 100) >= stall_pct;
      rnd           = gen_rand();
      soc_qready_i  = rnd[3:0] > 4'd4;
      if (!data_qvalid_i || q_fired) begin
        data_qvalid_i = 1'b0;
        free_id       = -1;
        for (int i = MaxOutstanding - 1; i >= 0; i--) begin
          if (!pending[i]) begin
            free_id = i;
          end
        end
        if (issue_count < issue_limit && free_id >= 0) begin
          data_qaddr_i  = stim_addr[issue_count];
          data_qwrite_i = stim_write[issue_count];
          data_qamo_i   = stim_amo[issue_count];
          data_qdata_i  = stim_data[issue_count];
          data_qstrb_i  = stim_strb[issue_count];
          data_qid_i    = MetaIdWidth'(free_id);
          data_qvalid_i = 1'b1;
          issue_count++;
        end
      end
      // Random SoC latency, one chance in four per cycle
      if (!soc_pvalid_i || s_fired) begin
        soc_pvalid_i = 1'b0;
        rnd          = gen_rand();
        if (soc_addr_q.size() > 0 && rnd[1:0] == 2'b00) begin
          soc_pvalid_i = 1'b1;
          soc_pwrite_i = soc_write_q[0];
          soc_pdata_i  = soc_write_q[0] ? '0 : ~soc_addr_q[0];
          soc_perror_i = soc_addr_q[0][4];
        end
      end
    end
  end

  initial begin : run_tests
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    int unsigned errs_before;
    int unsigned end_errs;
    end_errs = 0;
    for (int unsigned i = 0; i < TcdmWords; i++) begin
      add_txn(i * 4, 1'b1, AmoNone, gen_rand(), 4'hf);
    end
    for (int unsigned i = 0; i < TcdmWords; i++) begin
      add_txn(i * 4, 1'b0, AmoNone, '0, 4'h0);
    end
    repeat (Len2 / 2) begin
      a = tcdm_word_addr(gen_rand());
      r = gen_rand();
      add_txn(a, 1'b1, AmoNone, r, r[11:8]);
      add_txn(a, 1'b0, AmoNone, '0, 4'h0);
    end
    repeat (Len3 / 4) begin
      a = tcdm_word_addr(gen_rand());
      d = gen_rand();
      add_txn(a, 1'b0, AmoSwap, d, 4'hf);
      add_txn(a, 1'b0, AmoNone, '0, 4'h0);
      d = gen_rand();
      add_txn(a, 1'b0, AmoAdd, d, 4'hf);
      add_txn(a, 1'b0, AmoNone, '0, 4'h0);
    end
    repeat (Len4) begin
      r = gen_rand();
      add_txn(soc_word_addr(r), r[5], AmoNone, ~r, r[9:6]);
    end
    repeat (Len5) begin
      r = gen_rand();
      d = gen_rand();
      if (r[0]) begin
        add_txn(soc_word_addr(d), r[1], AmoNone, ~d, 4'hf);
      end else begin
        case (r[2:1])
          2'd0:    add_txn(tcdm_word_addr(d), 1'b0, AmoNone, '0, 4'h0);
          2'd1:    add_txn(tcdm_word_addr(d), 1'b1, AmoNone, r, r[7:4]);
          2'd2:    add_txn(tcdm_word_addr(d), 1'b0, AmoSwap, r, 4'hf);
          default: add_txn(tcdm_word_addr(d), 1'b0, AmoAdd, r, 4'hf);
        endcase
      end
    end

    wait (arst_n_i === 1'b1);
    @(posedge clk_i);
    assert (!data_pvalid_o && !soc_qvalid_o && !soc_pready_o)
    else begin
      print_error("valid outputs not idle after reset");
      end_errs++;
    end

    for (int t = 0; t < NrTests; t++) begin
      errs_before   = err_count;
      stall_pct     = test_stall[t];
      check_latency = (t == 0);
      issue_limit  += test_len[t];
      wait (resp_count == issue_limit);
      $display("Test %0d %s: %0d transactions, %0d errors", t + 1, test_name[t],
               test_len[t], err_count - errs_before);
    end
    check_latency = 1'b0;

    // Any late duplicate shows up in the monitor meanwhile
    repeat (20) @(posedge clk_i);
    assert (!data_pvalid_o && soc_addr_q.size() == 0)
    else begin
      print_error("responses or SoC requests left over after the last test");
      end_errs++;
    end

    $display("Checks: %0d, errors: %0d", check_count + 2, err_count + end_errs);
    if (err_count + end_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TotalTxns * 40 * ClkPeriod);
    $display("Timeout: not every issued request got its response in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: compile.f
rtl/shim_pkg.sv
rtl/meta_id_fifo.sv
rtl/addr_demux.sv
rtl/tcdm_bank.sv
rtl/tcdm_shim.sv
rtl/shim_subsystem_top.sv
test/tb_clk_gen.sv
test/tb_shim_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the shim testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_shim_top \
  -f compile.f \
  -o sim_tb_shim_top

./obj_dir/sim_tb_shim_top | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run_sim: testbench reported failures"
  exit 1
fi
echo "run_sim: no failures reported"
